// File: cache_pkg.sv
//==========================================================================
// L1 data cache shared definitions
// Geometry of the 8 KB four-way cache, the address field types and the
// request and response layouts of the L2 channel
//==========================================================================
`default_nettype none

package cache_pkg;

	// 4 ways of 32 sets, 64-byte lines, 8 KB in total
	localparam int num_ways = 4;
	localparam int num_sets = 32;

	// one outstanding load miss per strand
	localparam int num_strands = 4;

	// a line is 512 bits, with one byte-enable bit per byte on the L2 channel
	localparam int line_bits = 512;
	localparam int line_bytes = line_bits / 8;

	// number of this core unit on the shared L2 channel
	localparam logic [1:0] unit_id = 2'd1;

	// L2 operation codes, only the load is issued by this cache
	localparam logic [1:0] op_load = 2'd0;

	// address layout: [31:11] tag, [10:6] set index, [5:0] byte offset
	typedef logic [31:0] addr_t;
	typedef logic [20:0] tag_t;
	typedef logic [4:0] set_t;
	typedef logic [1:0] way_t;
	typedef logic [1:0] strand_t;
	typedef logic [num_strands-1:0] strand_mask_t;
	typedef logic [line_bits-1:0] line_t;

	// tag and set together name a line on the L2 channel
	typedef logic [25:0] line_addr_t;

	// request to the L2, held stable while valid until acknowledged
	typedef struct packed {
		logic [1:0] unit;
		strand_t strand;
		logic [1:0] op;
		way_t way;
		line_addr_t address;
		line_t data;
		logic [line_bytes-1:0] mask;
	} l2_req_t;

	// response from the L2, valid for a single cycle with no back-pressure
	// way and strand echo the values carried in the matching request
	typedef struct packed {
		logic valid;
		logic [1:0] unit;
		strand_t strand;
		logic [1:0] op;
		logic update;
		way_t way;
		line_t data;
	} l2_resp_t;

endpackage

`default_nettype wire

// File: cache_tag_mem.sv
//==========================================================================
// L1 data cache tag memory
// Tag and valid arrays for four ways, read in parallel and compared with
// the latched request tag to give hit and hit way one cycle later
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_tag_mem
(
	input wire logic clk,
	input wire logic reset_i,
	input wire logic access_i,
	input wire cache_pkg::set_t request_set_i,
	input wire cache_pkg::tag_t request_tag_i,
	input wire logic update_i,
	input wire cache_pkg::way_t update_way_i,
	input wire cache_pkg::set_t update_set_i,
	input wire cache_pkg::tag_t update_tag_i,
	output logic cache_hit_o,
	output cache_pkg::way_t hit_way_o
);
	import cache_pkg::*;

	// one tag array and one valid vector per way
	tag_t tags [num_ways][num_sets];
	logic [num_sets-1:0] valid [num_ways];

	// registered read of the requested set and the tag it is compared against
	tag_t tag_rd [num_ways];
	logic [num_ways-1:0] valid_rd;
	tag_t request_tag_latched;
	logic access_latched;
	logic [num_ways-1:0] way_match;

	// tag storage has no reset, only the valid bits say whether a tag counts
	always_ff @(posedge clk)
	begin
		if (update_i)
			tags[update_way_i][update_set_i] <= update_tag_i;
		// a fill at this edge is not seen by the read at the same edge
		for (int w = 0; w < num_ways; w++)
		begin
			tag_rd[w] <= tags[w][request_set_i];
			valid_rd[w] <= valid[w][request_set_i];
		end
		request_tag_latched <= request_tag_i;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int w = 0; w < num_ways; w++)
				valid[w] <= '0;
			access_latched <= 1'b0;
		end
		else
		begin
			access_latched <= access_i;
			// completing loads mark their line valid in the victim way
			if (update_i)
				valid[update_way_i][update_set_i] <= 1'b1;
		end
	end

	// compare all four ways at once, at most one of them should match
	always_comb
	begin
		hit_way_o = '0;
		for (int w = 0; w < num_ways; w++)
		begin
			way_match[w] = valid_rd[w] && tag_rd[w] == request_tag_latched;
			if (way_match[w])
				hit_way_o = way_t'(w);
		end
		cache_hit_o = access_latched && |way_match;
	end

	// the miss queue and collision logic must never load one line into two ways
	a_single_way: assert property (@(posedge clk) disable iff (reset_i)
		access_latched |-> $onehot0(way_match))
		else $error("line resident in more than one way");

endmodule

`default_nettype wire

// File: cache_lru.sv
//==========================================================================
// L1 data cache replacement
// Tree pseudo-LRU with three bits per set, giving the victim way of the
// latched request's set and marking a way most recently used
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_lru
(
	input wire logic clk,
	input wire logic reset_i,
	input wire cache_pkg::set_t set_i,
	input wire logic update_i,
	input wire cache_pkg::way_t new_mru_way_i,
	output cache_pkg::way_t victim_way_o
);
	import cache_pkg::*;

	// bit 0 is the root and picks a half, bit 1 picks within ways 0 and 1,
	// bit 2 picks within ways 2 and 3, a zero bit always points left
	typedef logic [2:0] lru_tree_t;

	lru_tree_t lru_bits [num_sets];
	lru_tree_t cur_bits;
	lru_tree_t new_bits;

	always_comb
	begin
		cur_bits = lru_bits[set_i];

		// walk the tree to the least recently used leaf
		if (cur_bits[0])
			victim_way_o = {1'b1, cur_bits[2]};
		else
			victim_way_o = {1'b0, cur_bits[1]};

		// point every bit on the new MRU way's path away from it
		new_bits = cur_bits;
		new_bits[0] = !new_mru_way_i[1];
		if (new_mru_way_i[1])
			new_bits[2] = !new_mru_way_i[0];
		else
			new_bits[1] = !new_mru_way_i[0];
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int s = 0; s < num_sets; s++)
				lru_bits[s] <= '0;
		end
		else if (update_i)
			lru_bits[set_i] <= new_bits;
	end

	// a way just made MRU is never the next victim of that same set
	a_mru_not_victim: assert property (@(posedge clk) disable iff (reset_i)
		update_i |=> set_i != $past(set_i) || victim_way_o != $past(new_mru_way_i))
		else $error("most recently used way chosen as victim");

endmodule

`default_nettype wire

// File: load_miss_queue.sv
//==========================================================================
// L1 data cache load miss queue
// One entry per strand, merging of misses to a pending line, round-robin
// issue on the L2 request channel and completion on the L2 response
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module load_miss_queue
(
	input wire logic clk,
	input wire logic reset_i,
	input wire logic request_i,
	input wire cache_pkg::tag_t tag_i,
	input wire cache_pkg::set_t set_i,
	input wire cache_pkg::way_t victim_way_i,
	input wire cache_pkg::strand_t strand_i,
	input wire logic l2_ack_i,
	input wire cache_pkg::l2_resp_t l2_resp_i,
	output cache_pkg::strand_mask_t load_complete_strands_o,
	output cache_pkg::set_t load_complete_set_o,
	output cache_pkg::tag_t load_complete_tag_o,
	output cache_pkg::way_t load_complete_way_o,
	output logic l2_req_valid_o,
	output cache_pkg::l2_req_t l2_req_o
);
	import cache_pkg::*;

	// a line being fetched and every strand that waits on it
	typedef struct packed {
		logic valid;
		logic issued;
		strand_mask_t waiting;
		tag_t tag;
		set_t set;
		way_t way;
	} lmq_entry_t;

	lmq_entry_t entries [num_strands];
	strand_t issue_ptr;
	strand_t ptr_next;
	logic merge_hit;
	strand_t merge_idx;
	logic resp_match;
	logic [num_strands-1:0] pending;
	logic [num_strands-1:0] pending_next;

	// a miss to a line that is already pending joins that entry
	always_comb
	begin
		merge_hit = 1'b0;
		merge_idx = strand_i;
		for (int i = 0; i < num_strands; i++)
		begin
			if (entries[i].valid && entries[i].tag == tag_i && entries[i].set == set_i)
			begin
				merge_hit = 1'b1;
				merge_idx = strand_t'(i);
			end
		end
	end

	// the pointer holds while its request waits for ack, otherwise it moves
	// to the nearest entry that will still be waiting after this edge
	always_comb
	begin
		for (int i = 0; i < num_strands; i++)
			pending[i] = entries[i].valid && !entries[i].issued;
		l2_req_valid_o = pending[issue_ptr];

		pending_next = pending;
		if (l2_req_valid_o && l2_ack_i)
			pending_next[issue_ptr] = 1'b0;
		if (request_i && !merge_hit)
			pending_next[strand_i] = 1'b1;

		ptr_next = issue_ptr;
		if (!pending_next[issue_ptr])
		begin
			// search downwards so that the closest entry after the pointer wins
			for (int i = num_strands - 1; i >= 1; i--)
			begin
				if (pending_next[issue_ptr + strand_t'(i)])
					ptr_next = issue_ptr + strand_t'(i);
			end
		end
	end

	// the request is taken straight from the entry under the pointer
	always_comb
	begin
		l2_req_o.unit = unit_id;
		l2_req_o.strand = issue_ptr;
		l2_req_o.op = op_load;
		l2_req_o.way = entries[issue_ptr].way;
		l2_req_o.address = {entries[issue_ptr].tag, entries[issue_ptr].set};
		l2_req_o.data = '0;
		l2_req_o.mask = '0;
	end

	// the response strand is the entry index that was sent with the request
	assign resp_match = l2_resp_i.valid && l2_resp_i.unit == unit_id
		&& l2_resp_i.op == op_load;
	assign load_complete_strands_o = resp_match ? entries[l2_resp_i.strand].waiting : '0;
	assign load_complete_set_o = entries[l2_resp_i.strand].set;
	assign load_complete_tag_o = entries[l2_resp_i.strand].tag;
	assign load_complete_way_o = entries[l2_resp_i.strand].way;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < num_strands; i++)
			begin
				entries[i].valid <= 1'b0;
				entries[i].issued <= 1'b0;
				entries[i].waiting <= '0;
			end
			issue_ptr <= '0;
		end
		else
		begin
			issue_ptr <= ptr_next;
			if (l2_req_valid_o && l2_ack_i)
				entries[issue_ptr].issued <= 1'b1;

			// completion is the only thing that frees an entry and its strands
			if (resp_match)
			begin
				entries[l2_resp_i.strand].valid <= 1'b0;
				entries[l2_resp_i.strand].issued <= 1'b0;
				entries[l2_resp_i.strand].waiting <= '0;
			end

			if (request_i)
			begin
				if (merge_hit)
				begin
					entries[merge_idx].waiting <= entries[merge_idx].waiting
						| (strand_mask_t'(1) << strand_i);
				end
				else
				begin
					entries[strand_i].valid <= 1'b1;
					entries[strand_i].issued <= 1'b0;
					entries[strand_i].waiting <= strand_mask_t'(1) << strand_i;
					entries[strand_i].tag <= tag_i;
					entries[strand_i].set <= set_i;
					entries[strand_i].way <= victim_way_i;
				end
			end
		end
	end

	// the L2 only answers requests it has acknowledged
	a_resp_issued: assert property (@(posedge clk) disable iff (reset_i)
		resp_match |-> entries[l2_resp_i.strand].issued)
		else $error("L2 response for an entry that was never issued");

	// once raised, a request stays put until the L2 takes it
	a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
		l2_req_valid_o && !l2_ack_i |=> l2_req_valid_o && $stable(l2_req_o))
		else $error("L2 request changed before acknowledge");

endmodule

`default_nettype wire

// File: l1_cache.sv
//==========================================================================
// L1 data cache top level
// Virtually indexed, virtually tagged, non-blocking 8 KB cache with one
// cycle of latency: four data banks, tag memory, LRU and load miss queue
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module l1_cache
(
	input wire logic clk,
	input wire logic reset_i,
	input wire logic access_i,
	input wire logic write_i,
	input wire cache_pkg::addr_t address_i,
	input wire cache_pkg::strand_t strand_i,
	input wire logic l2_ack_i,
	input wire cache_pkg::l2_resp_t l2_resp_i,
	output cache_pkg::line_t data_o,
	output logic cache_hit_o,
	output logic load_collision_o,
	output cache_pkg::strand_mask_t load_complete_strands_o,
	output logic l2_req_valid_o,
	output cache_pkg::l2_req_t l2_req_o
);
	import cache_pkg::*;

	// the part of a core request that is needed one cycle later
	typedef struct packed {
		logic write;
		strand_t strand;
		tag_t tag;
		set_t set;
	} core_req_t;

	set_t request_set;
	tag_t request_tag;
	logic access_latched;
	core_req_t req_latched;

	// one bank per way, all read in parallel at the request edge
	line_t banks [num_ways][num_sets];
	line_t bank_rd [num_ways];

	way_t hit_way;
	way_t victim_way;
	way_t new_mru_way;
	logic update_mru;
	logic read_miss;
	logic load_complete;
	set_t load_complete_set;
	tag_t load_complete_tag;
	way_t load_complete_way;
	logic collision_prev;
	logic collision_now;

	assign request_set = address_i[10:6];
	assign request_tag = address_i[31:11];

	always_ff @(posedge clk)
	begin
		if (reset_i)
			access_latched <= 1'b0;
		else
			access_latched <= access_i;
	end

	always_ff @(posedge clk)
	begin
		req_latched.write <= write_i;
		req_latched.strand <= strand_i;
		req_latched.tag <= request_tag;
		req_latched.set <= request_set;
	end

	// the fill lands in the way that was chosen as victim when the miss was queued
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < num_ways; w++)
			bank_rd[w] <= banks[w][request_set];
		if (load_complete)
			banks[l2_resp_i.way][load_complete_set] <= l2_resp_i.data;
	end

	// only the bank of the hitting way matters, data_o is ignored on a miss
	assign data_o = bank_rd[hit_way];

	assign load_complete = |load_complete_strands_o;

	cache_tag_mem u_tag_mem
	(
		.clk(clk),
		.reset_i(reset_i),
		.access_i(access_i),
		.request_set_i(request_set),
		.request_tag_i(request_tag),
		.update_i(load_complete),
		.update_way_i(load_complete_way),
		.update_set_i(load_complete_set),
		.update_tag_i(load_complete_tag),
		.cache_hit_o(cache_hit_o),
		.hit_way_o(hit_way)
	);

	// a line completing together with the lookup of the same line is not in
	// the tag memory yet, so that request would load it a second time
	always_ff @(posedge clk)
	begin
		if (reset_i)
			collision_prev <= 1'b0;
		else
			collision_prev <= load_complete && access_i
				&& load_complete_tag == request_tag && load_complete_set == request_set;
	end

	// also catch the line completing while the latched request is checked
	assign collision_now = load_complete && access_latched
		&& load_complete_tag == req_latched.tag && load_complete_set == req_latched.set;
	assign load_collision_o = collision_prev || collision_now;

	// writes never allocate and a colliding read is already being filled
	assign read_miss = access_latched && !req_latched.write && !cache_hit_o
		&& !load_collision_o;

	// a hit refreshes its way, a read miss protects the way that will be filled
	assign new_mru_way = cache_hit_o ? hit_way : victim_way;
	assign update_mru = cache_hit_o || read_miss;

	cache_lru u_lru
	(
		.clk(clk),
		.reset_i(reset_i),
		.set_i(req_latched.set),
		.update_i(update_mru),
		.new_mru_way_i(new_mru_way),
		.victim_way_o(victim_way)
	);

	load_miss_queue u_lmq
	(
		.clk(clk),
		.reset_i(reset_i),
		.request_i(read_miss),
		.tag_i(req_latched.tag),
		.set_i(req_latched.set),
		.victim_way_i(victim_way),
		.strand_i(req_latched.strand),
		.l2_ack_i(l2_ack_i),
		.l2_resp_i(l2_resp_i),
		.load_complete_strands_o(load_complete_strands_o),
		.load_complete_set_o(load_complete_set),
		.load_complete_tag_o(load_complete_tag),
		.load_complete_way_o(load_complete_way),
		.l2_req_valid_o(l2_req_valid_o),
		.l2_req_o(l2_req_o)
	);

endmodule

`default_nettype wire

// File: tb_l1_cache.sv
//==========================================================================
// L1 data cache testbench
// Drives a table of core accesses into the cache, models the L2 with
// random acknowledge and response delays and checks hits, data,
// collisions, completion masks and the L2 requests
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache;
	import cache_pkg::*;

	// flag bits of a table entry
	// chain drives the next entry in the very next cycle
	localparam logic [3:0] f_chain = 4'b1000;
	// wait for the strand's load to complete after the check
	localparam logic [3:0] f_wait = 4'b0100;
	// drive the access in the cycle of the next L2 response
	localparam logic [3:0] f_resp = 4'b0010;
	// the entry is expected to send one request to the L2
	localparam logic [3:0] f_req = 4'b0001;

	typedef struct packed {
		logic access;
		logic write;
		addr_t address;
		strand_t strand;
		logic exp_hit;
		logic exp_coll;
		logic [3:0] flags;
		strand_mask_t exp_mask;
	} stim_t;

	logic clk = 1'b0;
	logic reset;
	logic access;
	logic write;
	addr_t address;
	strand_t strand;
	logic l2_ack;
	l2_resp_t l2_resp;
	line_t data_o;
	logic cache_hit_o;
	logic load_collision_o;
	strand_mask_t load_complete_strands_o;
	logic l2_req_valid_o;
	l2_req_t l2_req_o;

	stim_t tbl [$];
	logic table_ready = 1'b0;
	int errors = 0;
	int passes = 0;
	int fails = 0;
	int exp_req_total = 0;

	// reference model of the resident lines and of the replacement tree
	tag_t res_tag [num_ways][num_sets];
	logic res_valid [num_ways][num_sets];
	logic [2:0] plru [num_sets];
	way_t pred_way [num_strands];

	// completions seen per strand and the mask that came with them
	logic seen [num_strands];
	strand_mask_t last_mask [num_strands];

	// L2 model state
	l2_req_t req_q [$];
	int unsigned due_q [$];
	int unsigned cycle = 0;
	int ack_wait = -1;
	int req_count = 0;
	event resp_driven;

	always #5 clk = ~clk;

	l1_cache u_dut
	(
		.clk(clk),
		.reset_i(reset),
		.access_i(access),
		.write_i(write),
		.address_i(address),
		.strand_i(strand),
		.l2_ack_i(l2_ack),
		.l2_resp_i(l2_resp),
		.data_o(data_o),
		.cache_hit_o(cache_hit_o),
		.load_collision_o(load_collision_o),
		.load_complete_strands_o(load_complete_strands_o),
		.l2_req_valid_o(l2_req_valid_o),
		.l2_req_o(l2_req_o)
	);

	// line content known to the testbench, in which every word depends on the line address
	function automatic line_t line_of(input line_addr_t la);
		line_t l;
		for (int i = 0; i < 16; i++)
			l[i*32 +: 32] = {2'b10, la, 4'(i)};
		return l;
	endfunction

	// a zero bit points left, to ways 0 and 1 at the root and to way 0 or 2 below it
	function automatic way_t plru_victim(input logic [2:0] b);
		if (!b[0])
			return b[1] ? 2'd1 : 2'd0;
		return b[2] ? 2'd3 : 2'd2;
	endfunction

	task automatic plru_touch(input set_t s, input way_t w);
		plru[s][0] = (w < 2);
		if (w < 2)
			plru[s][1] = (w == 0);
		else
			plru[s][2] = (w == 2);
	endtask

	function automatic way_t find_way(input set_t s, input tag_t t);
		way_t w;
		w = '0;
		for (int i = 0; i < num_ways; i++)
			if (res_valid[i][s] && res_tag[i][s] == t)
				w = way_t'(i);
		return w;
	endfunction

	task automatic check_line(input line_t got, input line_t exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_mask(input strand_mask_t got, input strand_mask_t exp,
		input string what);
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_way(input way_t got, input way_t exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic add_entry(input logic acc, input logic wr, input addr_t addr,
		input strand_t s, input logic hit, input logic coll, input logic [3:0] flags,
		input strand_mask_t mask);
		tbl.push_back('{acc, wr, addr, s, hit, coll, flags, mask});
		if (flags & f_req)
			exp_req_total++;
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before)
		begin
			passes++;
			$display("%s: pass", name);
		end
		else
		begin
			fails++;
			$display("%s: fail", name);
		end
	endtask

	task automatic drive(input stim_t e);
		access = e.access;
		write = e.write;
		address = e.address;
		strand = e.strand;
		// a read expected to be queued or merged waits for a fresh completion
		if (e.access && !e.write && !e.exp_hit && !e.exp_coll)
			seen[e.strand] = 1'b0;
	endtask

	task automatic drive_idle();
		access = 1'b0;
		write = 1'b0;
	endtask

	// hits refresh their way, read misses refresh the predicted victim
	task automatic update_model(input stim_t e);
		set_t s;
		tag_t t;
		way_t v;
		s = e.address[10:6];
		t = e.address[31:11];
		if (!e.access)
			return;
		if (e.exp_hit)
			plru_touch(s, find_way(s, t));
		else if (!e.write && !e.exp_coll)
		begin
			v = plru_victim(plru[s]);
			if (e.flags & f_req)
				pred_way[e.strand] = v;
			plru_touch(s, v);
		end
	endtask

	task automatic accept_request();
		int unsigned due;
		l2_ack = 1'b1;
		req_count++;
		check_way(l2_req_o.way, pred_way[l2_req_o.strand], "l2_req_o.way");
		check_flag(l2_req_o.unit == unit_id, 1'b1, "l2_req_o.unit is this cache");
		check_flag(l2_req_o.op == op_load, 1'b1, "l2_req_o.op is a load");
		due = cycle + 2 + $urandom % 4;
		// responses leave in acknowledge order and at most one per cycle
		if (due_q.size() != 0 && due <= due_q[$])
			due = due_q[$] + 1;
		req_q.push_back(l2_req_o);
		due_q.push_back(due);
	endtask

	task automatic send_response();
		l2_req_t r;
		r = req_q.pop_front();
		void'(due_q.pop_front());
		l2_resp.valid = 1'b1;
		l2_resp.unit = unit_id;
		l2_resp.strand = r.strand;
		l2_resp.op = op_load;
		l2_resp.way = r.way;
		l2_resp.data = line_of(r.address);
		res_tag[r.way][r.address[4:0]] = r.address[25:5];
		res_valid[r.way][r.address[4:0]] = 1'b1;
		-> resp_driven;
	endtask

	// the L2 model acknowledges after 0 to 3 cycles and answers 2 to 5 cycles later
	initial
	begin
		l2_ack = 1'b0;
		l2_resp = '0;
		void'($urandom(32'h255d));
		forever
		begin
			@(posedge clk);
			#1;
			cycle++;
			l2_ack = 1'b0;
			l2_resp = '0;
			if (!reset)
			begin
				if (due_q.size() != 0 && cycle >= due_q[0])
					send_response();
				if (l2_req_valid_o)
				begin
					if (ack_wait < 0)
						ack_wait = $urandom % 4;
					if (ack_wait == 0)
					begin
						accept_request();
						ack_wait = -1;
					end
					else
						ack_wait--;
				end
			end
		end
	end

	// record which strands completed and with which mask
	always @(negedge clk)
	begin
		for (int s = 0; s < num_strands; s++)
		begin
			if (load_complete_strands_o[s])
			begin
				seen[s] = 1'b1;
				last_mask[s] = load_complete_strands_o;
			end
		end
	end

	initial
	begin
		wait (table_ready);
		repeat (tbl.size() * 20) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", tbl.size() * 20);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		stim_t e;
		int err_before;
		logic pre_driven;

		reset = 1'b1;
		access = 1'b0;
		write = 1'b0;
		address = '0;
		strand = '0;
		for (int s = 0; s < num_sets; s++)
		begin
			plru[s] = '0;
			for (int w = 0; w < num_ways; w++)
				res_valid[w][s] = 1'b0;
		end
		for (int s = 0; s < num_strands; s++)
		begin
			seen[s] = 1'b0;
			last_mask[s] = '0;
			pred_way[s] = '0;
		end

		// read miss, repeat read and a write hit on the same line
		add_entry(1, 0, 32'h0001_2044, 0, 0, 0, f_req | f_wait, 4'b0001);
		add_entry(1, 0, 32'h0001_2070, 0, 1, 0, 4'b0000, 4'b0000);
		add_entry(1, 1, 32'h0001_2048, 0, 1, 0, 4'b0000, 4'b0000);
		// a write miss allocates nothing, so the read after it misses
		add_entry(1, 1, 32'h0003_4080, 1, 0, 0, 4'b0000, 4'b0000);
		add_entry(1, 0, 32'h0003_4080, 1, 0, 0, f_req | f_wait, 4'b0010);
		// five tags into set 5 fill ways 0, 2, 1, 3 and then evict way 0
		add_entry(1, 0, 32'h0008_0140, 2, 0, 0, f_req | f_wait, 4'b0100);
		add_entry(1, 0, 32'h0008_0940, 2, 0, 0, f_req | f_wait, 4'b0100);
		add_entry(1, 0, 32'h0008_1140, 2, 0, 0, f_req | f_wait, 4'b0100);
		add_entry(1, 0, 32'h0008_1940, 2, 0, 0, f_req | f_wait, 4'b0100);
		add_entry(1, 0, 32'h0008_2140, 2, 0, 0, f_req | f_wait, 4'b0100);
		add_entry(1, 0, 32'h0008_0940, 2, 1, 0, 4'b0000, 4'b0000);
		add_entry(1, 0, 32'h0008_1140, 2, 1, 0, 4'b0000, 4'b0000);
		add_entry(1, 0, 32'h0008_1940, 2, 1, 0, 4'b0000, 4'b0000);
		add_entry(1, 0, 32'h0008_2140, 2, 1, 0, 4'b0000, 4'b0000);
		add_entry(1, 0, 32'h0008_0140, 2, 0, 0, f_req | f_wait, 4'b0100);
		// two strands on one line in back-to-back cycles share one request
		add_entry(1, 0, 32'h0010_01C0, 0, 0, 0, f_req | f_chain, 4'b0000);
		add_entry(1, 0, 32'h0010_01C8, 1, 0, 0, f_wait, 4'b0011);
		add_entry(1, 0, 32'h0010_01C0, 2, 1, 0, 4'b0000, 4'b0000);
		// an access in the response cycle of its own line collides
		add_entry(1, 0, 32'h0018_0240, 1, 0, 0, f_req, 4'b0000);
		add_entry(1, 0, 32'h0018_0240, 2, 0, 1, f_resp, 4'b0000);
		add_entry(1, 0, 32'h0018_0240, 3, 1, 0, 4'b0000, 4'b0000);
		// four strands miss on four lines and queue behind the slow ack
		add_entry(1, 0, 32'h0020_02C0, 0, 0, 0, f_req | f_chain, 4'b0000);
		add_entry(1, 0, 32'h0020_0B00, 1, 0, 0, f_req | f_chain, 4'b0000);
		add_entry(1, 0, 32'h0020_1340, 2, 0, 0, f_req | f_chain, 4'b0000);
		add_entry(1, 0, 32'h0020_1B80, 3, 0, 0, f_req, 4'b0000);
		add_entry(0, 0, 32'h0000_0000, 0, 0, 0, f_wait, 4'b0001);
		add_entry(0, 0, 32'h0000_0000, 1, 0, 0, f_wait, 4'b0010);
		add_entry(0, 0, 32'h0000_0000, 2, 0, 0, f_wait, 4'b0100);
		add_entry(0, 0, 32'h0000_0000, 3, 0, 0, f_wait, 4'b1000);
		add_entry(1, 0, 32'h0020_02C0, 0, 1, 0, 4'b0000, 4'b0000);
		add_entry(1, 0, 32'h0020_0B00, 1, 1, 0, 4'b0000, 4'b0000);
		add_entry(1, 0, 32'h0020_1340, 2, 1, 0, 4'b0000, 4'b0000);
		add_entry(1, 0, 32'h0020_1B80, 3, 1, 0, 4'b0000, 4'b0000);
		table_ready = 1'b1;

		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		err_before = errors;
		check_flag(l2_req_valid_o, 1'b0, "l2_req_valid_o after reset");
		check_mask(load_complete_strands_o, '0, "load_complete_strands_o after reset");
		check_flag(cache_hit_o, 1'b0, "cache_hit_o after reset");
		check_flag(load_collision_o, 1'b0, "load_collision_o after reset");
		report_test("reset", err_before);

		pre_driven = 1'b0;
		for (int i = 0; i < tbl.size(); i++)
		begin
			e = tbl[i];
			err_before = errors;
			if (!pre_driven)
			begin
				if (e.flags & f_resp)
					@(resp_driven);
				else
				begin
					@(posedge clk);
					#1;
				end
				drive(e);
			end
			@(posedge clk);
			#1;
			pre_driven = (e.flags & f_chain) != 0 && i + 1 < tbl.size();
			if (pre_driven)
				drive(tbl[i+1]);
			else
				drive_idle();
			// the result of entry i is stable in this cycle
			@(negedge clk);
			check_flag(cache_hit_o, e.exp_hit, "cache_hit_o");
			check_flag(load_collision_o, e.exp_coll, "load_collision_o");
			if (e.exp_hit)
				check_line(data_o, line_of(e.address[31:6]), "data_o");
			update_model(e);
			if (e.flags & f_wait)
			begin
				// completions are recorded at the falling edge and read at the rising one
				@(posedge clk);
				while (!seen[e.strand])
					@(posedge clk);
				check_mask(last_mask[e.strand], e.exp_mask, "load_complete_strands_o");
				@(posedge clk);
			end
			report_test($sformatf("entry %0d", i), err_before);
		end

		// let the L2 drain, then count the requests it took
		while (l2_req_valid_o || due_q.size() != 0)
			@(posedge clk);
		repeat (3) @(posedge clk);
		err_before = errors;
		check_count(req_count, exp_req_total, "L2 request count");
		report_test("request count", err_before);

		$display("tests %0d, passed %0d, failed %0d", passes + fails, passes, fails);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
cache_pkg.sv
cache_tag_mem.sv
cache_lru.sv
load_miss_queue.sv
l1_cache.sv
tb_l1_cache.sv
